// File: common/bypassPkg.sv
// Shared widths, counts and types for the operand-read stage
// Word, register address and bypass stage index types

package bypassPkg;

    // Data path widths
    localparam int WordWidth = 32;
    localparam int RegAddrWidth = 5;

    // Registers per domain for integer and FP alike
    localparam int RegCount = 32;

    // Cycles a result stays forwardable before it retires
    localparam int BypassDepth = 3;

    // Read ports per domain
    localparam int IntReadPorts = 2;
    localparam int FpReadPorts = 3;

    // Stage index wide enough to name every bypass stage
    localparam int BypassIndexWidth = $clog2(BypassDepth);

    // Operand or result value
    typedef logic [WordWidth-1:0] wordT;

    // Architectural register index
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Position in the bypass pipeline where 0 is the youngest
    typedef logic [BypassIndexWidth-1:0] bypassIndexT;

endpackage

// File: bypass/bypassCam.sv
// Bypass pipeline with per-port CAM lookup and youngest-hit select
// Last stage drives the register file write port

`timescale 1ns/100ps

module bypassCam #(
    parameter int readPorts = 1,
    parameter bit zeroReg = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 flush,
    input  logic                                 stall,
    input  logic                                 writeEnable,
    input  bypassPkg::regAddrT                   writeAddr,
    input  bypassPkg::wordT                      writeValue,
    input  bypassPkg::regAddrT [readPorts-1:0]   readAddr,
    output bypassPkg::wordT    [readPorts-1:0]   readValue,
    output logic               [readPorts-1:0]   hit,
    output logic                                 retireEnable,
    output bypassPkg::regAddrT                   retireAddr,
    output bypassPkg::wordT                      retireValue
);

    localparam int LastStage = bypassPkg::BypassDepth - 1;

    // Lowest set bit wins since stage 0 holds the youngest result
    function automatic bypassPkg::bypassIndexT youngestHit(
        input logic [bypassPkg::BypassDepth-1:0] stageHit
    );
        bypassPkg::bypassIndexT index;
        index = '0;
        for (int i = bypassPkg::BypassDepth - 1; i >= 0; i--) begin
            if (stageHit[i]) begin
                index = bypassPkg::bypassIndexT'(i);
            end
        end
        return index;
    endfunction

    // Pipeline entries with stage 0 first
    logic [bypassPkg::BypassDepth-1:0] stageValid;
    bypassPkg::regAddrT stageAddr [bypassPkg::BypassDepth];
    bypassPkg::wordT stageValue [bypassPkg::BypassDepth];

    logic captureEnable;
    logic [bypassPkg::BypassDepth-1:0] portStageHit [readPorts];
    bypassPkg::bypassIndexT portIndex [readPorts];

    // Writes to a hardwired zero register never enter the pipeline
    assign captureEnable = writeEnable && !(zeroReg && (writeAddr == '0));

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            stageValid <= '0;
        end else if (!stall) begin
            stageValid[0] <= captureEnable;
            for (int i = 1; i < bypassPkg::BypassDepth; i++) begin
                stageValid[i] <= stageValid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stageAddr[0] <= writeAddr;
            stageValue[0] <= writeValue;
            for (int i = 1; i < bypassPkg::BypassDepth; i++) begin
                stageAddr[i] <= stageAddr[i-1];
                stageValue[i] <= stageValue[i-1];
            end
        end
    end

    // Address match against every valid stage, per read port
    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            for (int s = 0; s < bypassPkg::BypassDepth; s++) begin
                portStageHit[p][s] = stageValid[s] && (stageAddr[s] == readAddr[p]);
            end
            portIndex[p] = youngestHit(portStageHit[p]);
            hit[p] = |portStageHit[p];
            if (hit[p]) begin
                readValue[p] = stageValue[portIndex[p]];
            end else begin
                // Caller falls back to the register file on a miss
                readValue[p] = '0;
            end
        end
    end

    // Oldest entry leaves unless the pipeline holds or is being discarded
    assign retireEnable = stageValid[LastStage] && !stall && !flush;
    assign retireAddr = stageAddr[LastStage];
    assign retireValue = stageValue[LastStage];

endmodule

// File: regfile/regFile.sv
// Committed register file
// One synchronous write port and combinational read ports

`timescale 1ns/100ps

module regFile #(
    parameter int readPorts = 1
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 writeEnable,
    input  bypassPkg::regAddrT                   writeAddr,
    input  bypassPkg::wordT                      writeValue,
    input  bypassPkg::regAddrT [readPorts-1:0]   readAddr,
    output bypassPkg::wordT    [readPorts-1:0]   readValue
);

    bypassPkg::wordT regs [bypassPkg::RegCount];

    // All registers start at zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < bypassPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeValue;
        end
    end

    // No write-through here
    // the bypass still holds the entry in its retiring cycle
    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            readValue[p] = regs[readAddr[p]];
        end
    end

endmodule

// File: src/operandFetch.sv
// One register domain with bypass CAM and committed register file
// Per-port operand select with optional hardwired zero register

`timescale 1ns/100ps

module operandFetch #(
    parameter int readPorts = 1,
    parameter bit zeroReg = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 flush,
    input  logic                                 stall,
    input  logic                                 writeEnable,
    input  bypassPkg::regAddrT                   writeAddr,
    input  bypassPkg::wordT                      writeValue,
    input  bypassPkg::regAddrT [readPorts-1:0]   readAddr,
    output bypassPkg::wordT    [readPorts-1:0]   readValue,
    output logic               [readPorts-1:0]   hit
);

    bypassPkg::wordT [readPorts-1:0] camValue;
    logic [readPorts-1:0] camHit;
    bypassPkg::wordT [readPorts-1:0] rfValue;

    logic retireEnable;
    bypassPkg::regAddrT retireAddr;
    bypassPkg::wordT retireValue;

    bypassCam #(
        .readPorts (readPorts),
        .zeroReg   (zeroReg)
    ) u_bypass (
        .clk          (clk),
        .rstN         (rstN),
        .flush        (flush),
        .stall        (stall),
        .writeEnable  (writeEnable),
        .writeAddr    (writeAddr),
        .writeValue   (writeValue),
        .readAddr     (readAddr),
        .readValue    (camValue),
        .hit          (camHit),
        .retireEnable (retireEnable),
        .retireAddr   (retireAddr),
        .retireValue  (retireValue)
    );

    // Retiring bypass entries are the only writer
    regFile #(
        .readPorts (readPorts)
    ) u_regFile (
        .clk         (clk),
        .rstN        (rstN),
        .writeEnable (retireEnable),
        .writeAddr   (retireAddr),
        .writeValue  (retireValue),
        .readAddr    (readAddr),
        .readValue   (rfValue)
    );

    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            if (zeroReg && (readAddr[p] == '0)) begin
                readValue[p] = '0;
            end else if (camHit[p]) begin
                readValue[p] = camValue[p];
            end else begin
                // Committed value when not in flight
                readValue[p] = rfValue[p];
            end
        end
    end

    assign hit = camHit;

endmodule

// File: src/operandStage.sv
// Operand-read stage top level
// Integer and FP domains sharing flush and stall

`timescale 1ns/100ps

module operandStage (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic                                               flush,
    input  logic                                               stall,

    input  logic                                               intWriteEnable,
    input  bypassPkg::regAddrT                                 intWriteAddr,
    input  bypassPkg::wordT                                    intWriteValue,
    input  bypassPkg::regAddrT [bypassPkg::IntReadPorts-1:0]   intReadAddr,
    output bypassPkg::wordT    [bypassPkg::IntReadPorts-1:0]   intReadValue,
    output logic               [bypassPkg::IntReadPorts-1:0]   intHit,

    input  logic                                               fpWriteEnable,
    input  bypassPkg::regAddrT                                 fpWriteAddr,
    input  bypassPkg::wordT                                    fpWriteValue,
    input  bypassPkg::regAddrT [bypassPkg::FpReadPorts-1:0]    fpReadAddr,
    output bypassPkg::wordT    [bypassPkg::FpReadPorts-1:0]    fpReadValue,
    output logic               [bypassPkg::FpReadPorts-1:0]    fpHit
);

    // Integer x0 is hardwired to zero
    operandFetch #(
        .readPorts (bypassPkg::IntReadPorts),
        .zeroReg   (1'b1)
    ) u_intFetch (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .stall       (stall),
        .writeEnable (intWriteEnable),
        .writeAddr   (intWriteAddr),
        .writeValue  (intWriteValue),
        .readAddr    (intReadAddr),
        .readValue   (intReadValue),
        .hit         (intHit)
    );

    // f0 is an ordinary register
    operandFetch #(
        .readPorts (bypassPkg::FpReadPorts),
        .zeroReg   (1'b0)
    ) u_fpFetch (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .stall       (stall),
        .writeEnable (fpWriteEnable),
        .writeAddr   (fpWriteAddr),
        .writeValue  (fpWriteValue),
        .readAddr    (fpReadAddr),
        .readValue   (fpReadValue),
        .hit         (fpHit)
    );

endmodule

// File: sim/operandStage_properties.sv
// Shadow bypass pipelines and register files for both domains
// Concurrent checks on read values, hits, stall hold and flush

`timescale 1ns/100ps

module operandStageProperties (
    input logic                                               clk,
    input logic                                               rstN,
    input logic                                               flush,
    input logic                                               stall,
    input logic                                               intWriteEnable,
    input bypassPkg::regAddrT                                 intWriteAddr,
    input bypassPkg::wordT                                    intWriteValue,
    input bypassPkg::regAddrT [bypassPkg::IntReadPorts-1:0]   intReadAddr,
    input bypassPkg::wordT    [bypassPkg::IntReadPorts-1:0]   intReadValue,
    input logic               [bypassPkg::IntReadPorts-1:0]   intHit,
    input logic                                               fpWriteEnable,
    input bypassPkg::regAddrT                                 fpWriteAddr,
    input bypassPkg::wordT                                    fpWriteValue,
    input bypassPkg::regAddrT [bypassPkg::FpReadPorts-1:0]    fpReadAddr,
    input bypassPkg::wordT    [bypassPkg::FpReadPorts-1:0]    fpReadValue,
    input logic               [bypassPkg::FpReadPorts-1:0]    fpHit
);

    localparam int Depth = bypassPkg::BypassDepth;
    localparam bypassPkg::bypassIndexT LastStage = bypassPkg::bypassIndexT'(Depth - 1);

    int failCount = 0;

    // Index 0 is the integer domain, index 1 the FP domain
    logic shadowValid [2][Depth];
    bypassPkg::regAddrT shadowAddr [2][Depth];
    bypassPkg::wordT shadowValue [2][Depth];
    bypassPkg::wordT shadowRegs [2][bypassPkg::RegCount];

    logic enterValid [2];
    bypassPkg::regAddrT enterAddr [2];
    bypassPkg::wordT enterValue [2];

    bypassPkg::wordT [bypassPkg::IntReadPorts-1:0] intExpValue;
    logic [bypassPkg::IntReadPorts-1:0] intExpHit;
    bypassPkg::wordT [bypassPkg::FpReadPorts-1:0] fpExpValue;
    logic [bypassPkg::FpReadPorts-1:0] fpExpHit;

    // Integer writes to x0 never become visible
    always_comb begin
        enterValid[0] = intWriteEnable && (intWriteAddr != '0);
        enterAddr[0] = intWriteAddr;
        enterValue[0] = intWriteValue;
        enterValid[1] = fpWriteEnable;
        enterAddr[1] = fpWriteAddr;
        enterValue[1] = fpWriteValue;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int d = 0; d < 2; d++) begin
                for (int s = 0; s < Depth; s++) begin
                    shadowValid[d][s] <= 1'b0;
                end
                for (int r = 0; r < bypassPkg::RegCount; r++) begin
                    shadowRegs[d][r] <= '0;
                end
            end
        end else begin
            for (int d = 0; d < 2; d++) begin
                if (flush) begin
                    for (int s = 0; s < Depth; s++) begin
                        shadowValid[d][s] <= 1'b0;
                    end
                end else if (!stall) begin
                    // Oldest entry commits as the pipeline advances
                    if (shadowValid[d][LastStage]) begin
                        shadowRegs[d][shadowAddr[d][LastStage]] <= shadowValue[d][LastStage];
                    end
                    for (int s = Depth - 1; s > 0; s--) begin
                        shadowValid[d][s] <= shadowValid[d][s-1];
                        shadowAddr[d][s] <= shadowAddr[d][s-1];
                        shadowValue[d][s] <= shadowValue[d][s-1];
                    end
                    shadowValid[d][0] <= enterValid[d];
                    shadowAddr[d][0] <= enterAddr[d];
                    shadowValue[d][0] <= enterValue[d];
                end
            end
        end
    end

    // Scan oldest to youngest so the youngest match is left standing
    always_comb begin
        for (int p = 0; p < bypassPkg::IntReadPorts; p++) begin
            intExpHit[p] = 1'b0;
            intExpValue[p] = shadowRegs[0][intReadAddr[p]];
            for (int s = Depth - 1; s >= 0; s--) begin
                if (shadowValid[0][s] && (shadowAddr[0][s] == intReadAddr[p])) begin
                    intExpHit[p] = 1'b1;
                    intExpValue[p] = shadowValue[0][s];
                end
            end
            if (intReadAddr[p] == '0) begin
                intExpValue[p] = '0;
            end
        end
        for (int p = 0; p < bypassPkg::FpReadPorts; p++) begin
            fpExpHit[p] = 1'b0;
            fpExpValue[p] = shadowRegs[1][fpReadAddr[p]];
            for (int s = Depth - 1; s >= 0; s--) begin
                if (shadowValid[1][s] && (shadowAddr[1][s] == fpReadAddr[p])) begin
                    fpExpHit[p] = 1'b1;
                    fpExpValue[p] = shadowValue[1][s];
                end
            end
        end
    end

    intReadCheck: assert property (@(posedge clk) disable iff (!rstN)
        (intReadValue == intExpValue) && (intHit == intExpHit))
    else begin
        failCount++;
        $error("FAILED at %0t: integer operand or hit differs from the shadow model", $time);
    end

    fpReadCheck: assert property (@(posedge clk) disable iff (!rstN)
        (fpReadValue == fpExpValue) && (fpHit == fpExpHit))
    else begin
        failCount++;
        $error("FAILED at %0t: FP operand or hit differs from the shadow model", $time);
    end

    // A stalled cycle leaves every read unchanged for the same addresses
    stallHoldCheck: assert property (@(posedge clk) disable iff (!rstN)
        $past(stall && !flush && rstN) && $stable(intReadAddr) && $stable(fpReadAddr)
        |-> $stable(intReadValue) && $stable(intHit)
            && $stable(fpReadValue) && $stable(fpHit))
    else begin
        failCount++;
        $error("FAILED at %0t: read changed while the pipeline was stalled", $time);
    end

    flushClearCheck: assert property (@(posedge clk) disable iff (!rstN)
        $past(flush && rstN) |-> (intHit == '0) && (fpHit == '0))
    else begin
        failCount++;
        $error("FAILED at %0t: bypass hit seen in the cycle after a flush", $time);
    end

endmodule

bind operandStage operandStageProperties u_props (
    .clk            (clk),
    .rstN           (rstN),
    .flush          (flush),
    .stall          (stall),
    .intWriteEnable (intWriteEnable),
    .intWriteAddr   (intWriteAddr),
    .intWriteValue  (intWriteValue),
    .intReadAddr    (intReadAddr),
    .intReadValue   (intReadValue),
    .intHit         (intHit),
    .fpWriteEnable  (fpWriteEnable),
    .fpWriteAddr    (fpWriteAddr),
    .fpWriteValue   (fpWriteValue),
    .fpReadAddr     (fpReadAddr),
    .fpReadValue    (fpReadValue),
    .fpHit          (fpHit)
);

// File: sim/operandStageTb.sv
// Testbench top for the operand-read stage
// Directed and random stimulus, watchdog and closing result

`timescale 1ns/100ps

module operandStageTb;

    localparam int ClockPeriod = 100;
    localparam int ResetCycles = 16;
    localparam int DirectedCycles = 30;
    localparam int RandomCycles = 400;
    localparam int TimeoutCycles = ResetCycles + DirectedCycles + RandomCycles + 50;
    localparam int Seed = 71027;
    localparam int Settle = bypassPkg::BypassDepth + 2;

    logic clk = 1'b0;
    logic rstN;
    logic flush;
    logic stall;
    logic intWriteEnable;
    bypassPkg::regAddrT intWriteAddr;
    bypassPkg::wordT intWriteValue;
    bypassPkg::regAddrT [bypassPkg::IntReadPorts-1:0] intReadAddr;
    bypassPkg::wordT [bypassPkg::IntReadPorts-1:0] intReadValue;
    logic [bypassPkg::IntReadPorts-1:0] intHit;
    logic fpWriteEnable;
    bypassPkg::regAddrT fpWriteAddr;
    bypassPkg::wordT fpWriteValue;
    bypassPkg::regAddrT [bypassPkg::FpReadPorts-1:0] fpReadAddr;
    bypassPkg::wordT [bypassPkg::FpReadPorts-1:0] fpReadValue;
    logic [bypassPkg::FpReadPorts-1:0] fpHit;

    int seed = Seed;
    int errors;

    operandStage u_dut (
        .clk            (clk),
        .rstN           (rstN),
        .flush          (flush),
        .stall          (stall),
        .intWriteEnable (intWriteEnable),
        .intWriteAddr   (intWriteAddr),
        .intWriteValue  (intWriteValue),
        .intReadAddr    (intReadAddr),
        .intReadValue   (intReadValue),
        .intHit         (intHit),
        .fpWriteEnable  (fpWriteEnable),
        .fpWriteAddr    (fpWriteAddr),
        .fpWriteValue   (fpWriteValue),
        .fpReadAddr     (fpReadAddr),
        .fpReadValue    (fpReadValue),
        .fpHit          (fpHit)
    );

    initial begin
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // Drive one cycle of write, stall and flush levels on the falling edge
    task automatic driveCycle(
        input logic intEnable,
        input bypassPkg::regAddrT intAddr,
        input bypassPkg::wordT intValue,
        input logic fpEnable,
        input bypassPkg::regAddrT fpAddr,
        input bypassPkg::wordT fpValue,
        input logic stallIn,
        input logic flushIn
    );
        @(negedge clk);
        intWriteEnable = intEnable;
        intWriteAddr = intAddr;
        intWriteValue = intValue;
        fpWriteEnable = fpEnable;
        fpWriteAddr = fpAddr;
        fpWriteValue = fpValue;
        stall = stallIn;
        flush = flushIn;
    endtask

    task automatic idleCycles(input int cycles);
        repeat (cycles) begin
            driveCycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic pointReads(
        input bypassPkg::regAddrT int0,
        input bypassPkg::regAddrT int1,
        input bypassPkg::regAddrT fp0,
        input bypassPkg::regAddrT fp1,
        input bypassPkg::regAddrT fp2
    );
        intReadAddr[0] = int0;
        intReadAddr[1] = int1;
        fpReadAddr[0] = fp0;
        fpReadAddr[1] = fp1;
        fpReadAddr[2] = fp2;
    endtask

    // Small address range so writes and reads collide often
    task automatic randomCycle();
        bypassPkg::regAddrT intBase;
        bypassPkg::regAddrT fpBase;
        driveCycle(($unsigned($random(seed)) % 2) == 0,
                   bypassPkg::regAddrT'($unsigned($random(seed)) % 8), $random(seed),
                   ($unsigned($random(seed)) % 2) == 0,
                   bypassPkg::regAddrT'($unsigned($random(seed)) % 8), $random(seed),
                   ($unsigned($random(seed)) % 100) < 10,
                   ($unsigned($random(seed)) % 100) < 3);
        intBase = bypassPkg::regAddrT'($unsigned($random(seed)) % 8);
        fpBase = bypassPkg::regAddrT'($unsigned($random(seed)) % 8);
        pointReads(intBase, intBase + 5'd1, fpBase, fpBase + 5'd1, fpBase + 5'd2);
    endtask

    initial begin
        rstN = 1'b0;
        pointReads('0, '0, '0, '0, '0);
        intWriteEnable = 1'b0;
        intWriteAddr = '0;
        intWriteValue = '0;
        fpWriteEnable = 1'b0;
        fpWriteAddr = '0;
        fpWriteValue = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;

        // Forwarding where the youngest of two writes to one register wins
        pointReads(5'd5, 5'd5, 5'd7, 5'd7, 5'd7);
        driveCycle(1'b1, 5'd5, 32'h1111_0005, 1'b1, 5'd7, 32'h2222_0007, 1'b0, 1'b0);
        driveCycle(1'b1, 5'd5, 32'h3333_0005, 1'b1, 5'd7, 32'h4444_0007, 1'b0, 1'b0);
        idleCycles(Settle);

        // x0 stays zero while f0 behaves like any register
        pointReads(5'd0, 5'd5, 5'd0, 5'd7, 5'd1);
        driveCycle(1'b1, 5'd0, 32'hdead_0000, 1'b1, 5'd0, 32'h5555_0000, 1'b0, 1'b0);
        idleCycles(Settle);

        // Writes presented during stall must stay invisible
        pointReads(5'd9, 5'd10, 5'd3, 5'd11, 5'd0);
        driveCycle(1'b1, 5'd9, 32'h6666_0009, 1'b1, 5'd3, 32'h7777_0003, 1'b0, 1'b0);
        repeat (4) begin
            driveCycle(1'b1, 5'd10, 32'h8888_000a, 1'b1, 5'd11, 32'h9999_000b, 1'b1, 1'b0);
        end
        idleCycles(Settle);

        // Flush right behind a write
        pointReads(5'd12, 5'd9, 5'd4, 5'd3, 5'd0);
        driveCycle(1'b1, 5'd12, 32'haaaa_000c, 1'b1, 5'd4, 32'hbbbb_0004, 1'b0, 1'b0);
        driveCycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, 1'b1);
        idleCycles(Settle);

        for (int c = 0; c < RandomCycles; c++) begin
            randomCycle();
        end
        idleCycles(Settle);

        errors = u_dut.u_props.failCount;
        $display("Run complete: %0d random cycles, %0d errors", RandomCycles, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the reset, directed and random lengths
    initial begin
        #(TimeoutCycles * ClockPeriod);
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: files.f
common/bypassPkg.sv
bypass/bypassCam.sv
regfile/regFile.sv
src/operandFetch.sv
src/operandStage.sv
sim/operandStage_properties.sv
sim/operandStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the operand-read stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module operandStageTb -Mdir obj_dir -f files.f \
    > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/VoperandStageTb +verilator+error+limit+100000 > sim.log 2>&1 \
    || echo "Simulator returned a failing status"

grep -qF '*** PASSED ***' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
